//--- rtl/isaPkg.sv
package isaPkg;

    localparam int opcodeWidth = 5;
    localparam int regIdxWidth = 4;
    localparam int immWidth    = 19;
    localparam int padWidth    = 15; // Spare low bits of a register-format word.

    // Opcode values as they appear in bits 31..27 of the instruction word.
    typedef enum logic [opcodeWidth-1:0] {
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opShr  = 5'd5,
        opShl  = 5'd6,
        opRor  = 5'd7,
        opRol  = 5'd8,
        opAnd  = 5'd9,
        opOr   = 5'd10,
        opAddi = 5'd11,
        opAndi = 5'd12,
        opOri  = 5'd13,
        opMul  = 5'd14,
        opNeg  = 5'd16,
        opNot  = 5'd17
    } opcodeT;

    typedef struct packed {
        opcodeT                 opcode;
        logic [regIdxWidth-1:0] ra; // Destination.
        logic [regIdxWidth-1:0] rb;
        logic [regIdxWidth-1:0] rc;
        logic [padWidth-1:0]    pad;
    } rFormatT;

    typedef struct packed {
        opcodeT                 opcode;
        logic [regIdxWidth-1:0] ra;
        logic [regIdxWidth-1:0] rb;
        logic [immWidth-1:0]    c; // Signed constant.
    } iFormatT;

    // One fetched word, read either as three registers or as two plus a constant.
    typedef union packed {
        rFormatT rFormat;
        iFormatT iFormat;
    } instrT;

endpackage

//--- rtl/datapathPkg.sv
package datapathPkg;

    localparam int dataWidth = 32;
    localparam int regCount  = 16;

    // One micro-step of control, applied for a single clock.
    typedef struct packed {
        // Load strobes.
        logic pcIn;
        logic irIn;
        logic marIn;
        logic mdrIn;
        logic read;     // MDR takes memory data instead of the bus.
        logic yIn;
        logic zIn;
        logic rIn;
        // Bus drivers, at most one high.
        logic pcOut;
        logic mdrOut;
        logic zHighOut;
        logic zLowOut;
        logic rOut;
        logic cOut;
        // Register field selects.
        logic gra;
        logic grb;
        logic grc;
        logic baRead;   // R0 reads as zero.
        logic incPc;    // ALU adds one to the bus.
    } ctrlT;

    // Everything visible from outside the datapath.
    typedef struct packed {
        logic [dataWidth-1:0] busData;
        logic [dataWidth-1:0] pcData;
        logic [dataWidth-1:0] irData;
        logic [dataWidth-1:0] marData;
        logic [dataWidth-1:0] mdrData;
        logic [dataWidth-1:0] yData;
        logic [dataWidth-1:0] zHigh;
        logic [dataWidth-1:0] zLow;
    } viewT;

endpackage

//--- rtl/registerFile.sv
`timescale 1ns/1ns
module registerFile (
    input  logic                             clk,
    input  logic                             arstN,
    input  datapathPkg::ctrlT                ctrl,
    input  isaPkg::instrT                    ir,
    input  logic [datapathPkg::dataWidth-1:0] busData,
    output logic [datapathPkg::dataWidth-1:0] regData
);
    import datapathPkg::*;
    import isaPkg::*;

    logic [dataWidth-1:0]   regs [regCount];
    logic [regIdxWidth-1:0] regIdx;

    // Select and encode. The strobes mask the IR fields into one index.
    assign regIdx = ({regIdxWidth{ctrl.gra}} & ir.rFormat.ra)
                  | ({regIdxWidth{ctrl.grb}} & ir.rFormat.rb)
                  | ({regIdxWidth{ctrl.grc}} & ir.rFormat.rc);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (ctrl.rIn)
        begin
            regs[regIdx] <= busData;
        end
    end

    // R0 used as a base address reads zero
    always_comb
    begin
        if (ctrl.baRead && (regIdx == '0))
        begin
            regData = '0;
        end
        else
        begin
            regData = regs[regIdx];
        end
    end

endmodule

//--- rtl/specialRegisters.sv
`timescale 1ns/1ns
module specialRegisters (
    input  logic                               clk,
    input  logic                               arstN,
    input  datapathPkg::ctrlT                  ctrl,
    input  logic [datapathPkg::dataWidth-1:0]   busData,
    input  logic [datapathPkg::dataWidth-1:0]   mDataIn,
    input  logic [2*datapathPkg::dataWidth-1:0] aluResult,
    output datapathPkg::viewT                  view
);
    import datapathPkg::*;

    logic [dataWidth-1:0] mdrNext;

    assign mdrNext = ctrl.read ? mDataIn : busData; // Memory read or bus write.

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            view.pcData  <= '0;
            view.irData  <= '0;
            view.marData <= '0;
            view.mdrData <= '0;
            view.yData   <= '0;
            view.zHigh   <= '0;
            view.zLow    <= '0;
        end
        else
        begin
            if (ctrl.pcIn)
            begin
                view.pcData <= busData;
            end
            if (ctrl.irIn)
            begin
                view.irData <= busData;
            end
            if (ctrl.marIn)
            begin
                view.marData <= busData; // Address towards memory.
            end
            if (ctrl.mdrIn)
            begin
                view.mdrData <= mdrNext;
            end
            if (ctrl.yIn)
            begin
                view.yData <= busData; // First ALU operand.
            end
            if (ctrl.zIn)
            begin
                // Full 64-bit result, high word only non-zero for a product.
                view.zHigh <= aluResult[2*dataWidth-1:dataWidth];
                view.zLow  <= aluResult[dataWidth-1:0];
            end
        end
    end

    assign view.busData = busData; // Current bus value for observation.

endmodule

//--- rtl/busMux.sv
`timescale 1ns/1ns
module busMux (
    input  datapathPkg::ctrlT                 ctrl,
    input  logic [datapathPkg::dataWidth-1:0] regData,
    input  isaPkg::instrT                     ir,
    input  logic [datapathPkg::dataWidth-1:0] pcData,
    input  logic [datapathPkg::dataWidth-1:0] mdrData,
    input  logic [datapathPkg::dataWidth-1:0] zHigh,
    input  logic [datapathPkg::dataWidth-1:0] zLow,
    output logic [datapathPkg::dataWidth-1:0] busData
);
    import datapathPkg::*;
    import isaPkg::*;

    logic [dataWidth-1:0] immData;

    // Sign-extend the 19-bit constant.
    assign immData = {{(dataWidth-immWidth){ir.iFormat.c[immWidth-1]}}, ir.iFormat.c};

    always_comb
    begin
        busData = '0; // Nobody drives, bus reads zero.
        unique0 case (1'b1)
            ctrl.pcOut:    busData = pcData;
            ctrl.mdrOut:   busData = mdrData;
            ctrl.zHighOut: busData = zHigh;
            ctrl.zLowOut:  busData = zLow;
            ctrl.rOut:     busData = regData;
            ctrl.cOut:     busData = immData;
            default:       busData = '0;
        endcase
    end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ns
module alu (
    input  datapathPkg::ctrlT                   ctrl,
    input  isaPkg::instrT                       ir,
    input  logic [datapathPkg::dataWidth-1:0]   yData,
    input  logic [datapathPkg::dataWidth-1:0]   busData,
    output logic [2*datapathPkg::dataWidth-1:0] result
);
    import datapathPkg::*;
    import isaPkg::*;

    logic [4:0]                  shamt;
    logic [2*dataWidth-1:0]      yTwice;
    logic [2*dataWidth-1:0]      rolWide;
    logic signed [2*dataWidth-1:0] product;

    assign shamt   = busData[4:0];      // Low five bits of B.
    assign yTwice  = {yData, yData};    // Rotates come out of a doubled word.
    assign rolWide = yTwice << shamt;
    assign product = $signed(yData) * $signed(busData);

    always_comb
    begin
        result = '0;
        if (ctrl.incPc)
        begin
            result[dataWidth-1:0] = busData + 1'b1; // PC step during fetch.
        end
        else
        begin
            case (ir.rFormat.opcode)
                opAdd, opAddi:
                begin
                    result[dataWidth-1:0] = yData + busData;
                end
                opSub:
                begin
                    result[dataWidth-1:0] = yData - busData;
                end
                opAnd, opAndi:
                begin
                    result[dataWidth-1:0] = yData & busData;
                end
                opOr, opOri:
                begin
                    result[dataWidth-1:0] = yData | busData;
                end
                opShr:
                begin
                    result[dataWidth-1:0] = yData >> shamt;
                end
                opShl:
                begin
                    result[dataWidth-1:0] = yData << shamt;
                end
                opRor:
                begin
                    result[dataWidth-1:0] = yTwice[dataWidth-1:0] >> shamt
                                          | yData << (dataWidth - shamt);
                end
                opRol:
                begin
                    result[dataWidth-1:0] = rolWide[2*dataWidth-1:dataWidth];
                end
                opMul:
                begin
                    result = product; // Only case with a live high word.
                end
                opNeg:
                begin
                    result[dataWidth-1:0] = -busData;
                end
                opNot:
                begin
                    result[dataWidth-1:0] = ~busData;
                end
                default:
                begin
                    result = '0;
                end
            endcase
        end
    end

endmodule

//--- rtl/datapath.sv
`timescale 1ns/1ns
module datapath (
    input  logic                              clk,
    input  logic                              arstN,
    input  datapathPkg::ctrlT                 ctrl,
    input  logic [datapathPkg::dataWidth-1:0] mDataIn,
    output datapathPkg::viewT                 view
);
    import datapathPkg::*;
    import isaPkg::*;

    logic [dataWidth-1:0]   busData;
    logic [dataWidth-1:0]   regData;
    logic [2*dataWidth-1:0] aluResult;
    instrT                  irWord;

    assign irWord = view.irData; // IR as seen by the field decoders.

    registerFile i_registerFile (
        .clk     (clk),
        .arstN   (arstN),
        .ctrl    (ctrl),
        .ir      (irWord),
        .busData (busData),
        .regData (regData)
    );

    specialRegisters i_specialRegisters (
        .clk       (clk),
        .arstN     (arstN),
        .ctrl      (ctrl),
        .busData   (busData),
        .mDataIn   (mDataIn),
        .aluResult (aluResult),
        .view      (view)
    );

    busMux i_busMux (
        .ctrl    (ctrl),
        .regData (regData),
        .ir      (irWord),
        .pcData  (view.pcData),
        .mdrData (view.mdrData),
        .zHigh   (view.zHigh),
        .zLow    (view.zLow),
        .busData (busData)
    );

    // Y is operand A, the bus is operand B.
    alu i_alu (
        .ctrl    (ctrl),
        .ir      (irWord),
        .yData   (view.yData),
        .busData (busData),
        .result  (aluResult)
    );

endmodule

//--- sim/clockGen.sv
`timescale 1ns/1ns
module clockGen (
    output logic clk,
    output logic arstN
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period.
    end

    initial
    begin
        arstN = 1'b0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1; // Released on the tenth rising edge.
    end

endmodule

//--- sim/datapathProperties.sv
`timescale 1ns/1ns
module datapathProperties (
    input logic              clk,
    input logic              arstN,
    input datapathPkg::ctrlT ctrl,
    input datapathPkg::viewT view
);
    import datapathPkg::*;

    logic [5:0] outStrobes;
    int         propFails = 0; // Read by the testbench for its verdict.

    assign outStrobes = {ctrl.pcOut, ctrl.mdrOut, ctrl.zHighOut,
                         ctrl.zLowOut, ctrl.rOut, ctrl.cOut};

    singleDriver: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0(outStrobes))
    else
    begin
        propFails++;
        $error("More than one bus driver is enabled.");
    end

    idleBusZero: assert property (@(posedge clk) disable iff (!arstN)
        (outStrobes == '0) |-> (view.busData == '0))
    else
    begin
        propFails++;
        $error("Bus is not zero while no driver is enabled.");
    end

    // The PC is written from Z low during T1.
    pcStep: assert property (@(posedge clk) disable iff (!arstN)
        (ctrl.pcIn && ctrl.zLowOut) |=> (view.pcData == $past(view.pcData) + 1))
    else
    begin
        propFails++;
        $error("PC did not advance by one after the fetch step.");
    end

    irHold: assert property (@(posedge clk) disable iff (!arstN)
        !ctrl.irIn |=> $stable(view.irData))
    else
    begin
        propFails++;
        $error("IR changed without its load strobe.");
    end

endmodule

//--- sim/datapathChecker.sv
`timescale 1ns/1ns
module datapathChecker (
    input  logic                                clk,
    input  logic                                arstN,
    input  datapathPkg::ctrlT                   ctrl,
    input  datapathPkg::viewT                   view,
    input  logic [2*datapathPkg::dataWidth-1:0] expData,
    input  logic                                expWide,
    input  int                                  rowIdx,
    output int                                  rowsDone,
    output int                                  errCount
);
    import datapathPkg::*;

    logic                 resetChecked;
    logic                 pcPending;
    logic                 lowPending; // Product low word seen, high word still due.
    int                   fetchCount;
    logic [dataWidth-1:0] lowSeen;

    task automatic finishRow(input logic [2*dataWidth-1:0] got,
                             input logic [2*dataWidth-1:0] want);
        if (got !== want)
        begin
            errCount++;
            $display("ERR %0t: row %0d result %h, expected %h", $time, rowIdx, got, want);
        end
        else
        begin
            $display("row %0d ok: %h", rowIdx, got);
        end
        rowsDone++;
    endtask

    initial
    begin
        rowsDone     = 0;
        errCount     = 0;
        resetChecked = 1'b0;
        pcPending    = 1'b0;
        lowPending   = 1'b0;
        fetchCount   = 0;
    end

    // Mid-cycle sampling, when bus and registers have settled.
    always @(negedge clk)
    begin
        if (arstN)
        begin
            if (!resetChecked)
            begin
                resetChecked = 1'b1;
                if (view !== '0)
                begin
                    errCount++;
                    $display("ERR %0t: view is not zero after reset", $time);
                end
                else
                begin
                    $display("reset ok: every view field reads zero");
                end
            end
            if (pcPending && (view.pcData !== fetchCount))
            begin
                errCount++;
                $display("ERR %0t: PC %0d after fetch %0d", $time, view.pcData, fetchCount);
            end
            if (pcPending && (view.marData !== fetchCount - 1)) // MAR took the old PC at T0.
            begin
                errCount++;
                $display("ERR %0t: MAR %0d at fetch %0d", $time, view.marData, fetchCount);
            end
            pcPending = 1'b0;
            if (ctrl.pcIn)
            begin
                fetchCount++;
                pcPending = 1'b1;
            end
            if (ctrl.zLowOut && ctrl.rIn) // Write-back step T5.
            begin
                if (expWide)
                begin
                    lowSeen    = view.busData;
                    lowPending = 1'b1;
                end
                else
                begin
                    finishRow({32'h0, view.busData}, {32'h0, expData[dataWidth-1:0]});
                end
            end
            if (ctrl.zHighOut && lowPending)
            begin
                lowPending = 1'b0;
                finishRow({view.busData, lowSeen}, expData);
            end
        end
    end

endmodule

//--- sim/datapathTb.sv
`timescale 1ns/1ns
module datapathTb;
    import datapathPkg::*;
    import isaPkg::*;

    typedef struct packed {
        opcodeT      op;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [31:0] b;     // Zero means random.
        logic [31:0] c;     // Zero means random.
        logic [18:0] imm;
        logic        chain; // Operand B is the previous row's result.
        logic        base;  // Operand B read with baRead.
    } rowT;

    logic        clk;
    logic        arstN;
    ctrlT        ctrl;
    logic [31:0] mDataIn;
    viewT        view;
    logic [63:0] expData;
    logic        expWide;
    int          rowIdx;
    int          rowsDone;
    int          errCount;
    rowT         rows [16];

    clockGen i_clockGen (.clk(clk), .arstN(arstN));

    datapath i_dut (.clk(clk), .arstN(arstN), .ctrl(ctrl), .mDataIn(mDataIn), .view(view));

    datapathChecker i_checker (
        .clk(clk), .arstN(arstN), .ctrl(ctrl), .view(view), .expData(expData),
        .expWide(expWide), .rowIdx(rowIdx), .rowsDone(rowsDone), .errCount(errCount)
    );

    bind datapath datapathProperties i_props (.clk(clk), .arstN(arstN), .ctrl(ctrl), .view(view));

    task automatic applyStep(input ctrlT c, input logic [31:0] d);
        @(posedge clk);
        ctrl    <= c;
        mDataIn <= d;
    endtask

    function automatic logic [63:0] computeExpected(input opcodeT op, input logic [31:0] y,
                                                    input logic [31:0] b);
        logic [4:0]         n;
        logic signed [63:0] p;
        n = b[4:0];
        p = $signed({{32{y[31]}}, y}) * $signed({{32{b[31]}}, b});
        case (op)
            opAdd, opAddi: return {32'h0, y + b};
            opSub:         return {32'h0, y - b};
            opAnd, opAndi: return {32'h0, y & b};
            opOr, opOri:   return {32'h0, y | b};
            opShr:         return {32'h0, y >> n};
            opShl:         return {32'h0, y << n};
            opRor:         return {32'h0, (y >> n) | (y << (6'd32 - n))};
            opRol:         return {32'h0, (y << n) | (y >> (6'd32 - n))};
            opMul:         return p;
            opNeg:         return {32'h0, -b};
            opNot:         return {32'h0, ~b};
            default:       return '0;
        endcase
    endfunction

    initial
    begin
        rowT         r;
        instrT       word;
        logic        isImm;
        logic [31:0] yVal;
        logic [31:0] bVal;
        logic [31:0] prevResult;
        logic [63:0] want;
        ctrl    = '0;
        mDataIn = '0;
        expData = '0;
        expWide = 1'b0;
        rowIdx  = 0;
        void'($urandom(32'h4710_86bd));
        rows = '{
            '{opAdd,  4'd3,  4'd1, 4'd2, 32'h0,         32'h0,         19'h0,     1'b0, 1'b0},
            '{opSub,  4'd4,  4'd3, 4'd2, 32'h0,         32'h0,         19'h0,     1'b1, 1'b0},
            '{opAnd,  4'd5,  4'd1, 4'd2, 32'hF0F0_1234, 32'h0,         19'h0,     1'b0, 1'b0},
            '{opOr,   4'd6,  4'd1, 4'd2, 32'h0,         32'h0,         19'h0,     1'b0, 1'b0},
            '{opShr,  4'd7,  4'd1, 4'd2, 32'h8000_0001, 32'd7,         19'h0,     1'b0, 1'b0},
            '{opShl,  4'd8,  4'd1, 4'd2, 32'h0,         32'd31,        19'h0,     1'b0, 1'b0},
            '{opRor,  4'd9,  4'd1, 4'd2, 32'h1234_5678, 32'd4,         19'h0,     1'b0, 1'b0},
            '{opRol,  4'd10, 4'd1, 4'd2, 32'h0,         32'd13,        19'h0,     1'b0, 1'b0},
            '{opNeg,  4'd11, 4'd1, 4'd2, 32'h0,         32'h0,         19'h0,     1'b0, 1'b0},
            '{opNot,  4'd12, 4'd1, 4'd2, 32'h0,         32'h00FF_00FF, 19'h0,     1'b0, 1'b0},
            '{opAddi, 4'd13, 4'd1, 4'd0, 32'h0,         32'h0,         19'h7FFF0, 1'b0, 1'b0},
            '{opAndi, 4'd14, 4'd1, 4'd0, 32'hFFFF_FFFF, 32'h0,         19'h3FFFF, 1'b0, 1'b0},
            '{opOri,  4'd15, 4'd1, 4'd0, 32'h0,         32'h0,         19'h40001, 1'b0, 1'b0},
            '{opMul,  4'd2,  4'd1, 4'd3, 32'hFFFF_FFF9, 32'h0,         19'h0,     1'b0, 1'b0},
            '{opAdd,  4'd1,  4'd0, 4'd5, 32'h0,         32'h0,         19'h0,     1'b0, 1'b1},
            '{opAnd,  4'd6,  4'd1, 4'd4, 32'h0,         32'h0,         19'h0,     1'b1, 1'b0}
        };
        foreach (rows[i])
        begin
            if (rows[i].b == '0)
            begin
                rows[i].b = $urandom();
            end
            if (rows[i].c == '0)
            begin
                rows[i].c = $urandom();
            end
        end
        prevResult = '0;
        wait (arstN === 1'b1);
        for (int n = 0; n < $size(rows); n++)
        begin
            r     = rows[n];
            isImm = r.op inside {opAddi, opAndi, opOri};
            word  = '0;
            if (isImm)
            begin
                word.iFormat = '{r.op, r.ra, r.rb, r.imm};
            end
            else
            begin
                word.rFormat = '{r.op, r.ra, r.rb, r.rc, 15'h0};
            end
            yVal = r.base ? 32'h0 : (r.chain ? prevResult : r.b);
            bVal = isImm ? {{13{r.imm[18]}}, r.imm} : r.c;
            want = computeExpected(r.op, yVal, bVal);
            applyStep(ctrlT'{pcOut: 1'b1, marIn: 1'b1, incPc: 1'b1, zIn: 1'b1, default: 1'b0}, '0);
            applyStep(ctrlT'{zLowOut: 1'b1, pcIn: 1'b1, read: 1'b1, mdrIn: 1'b1, default: 1'b0},
                      word);
            applyStep(ctrlT'{mdrOut: 1'b1, irIn: 1'b1, default: 1'b0}, '0);
            // Operand loads follow T2 so that IR already holds rb and rc.
            if (!r.chain)
            begin
                applyStep(ctrlT'{read: 1'b1, mdrIn: 1'b1, default: 1'b0}, r.b);
                applyStep(ctrlT'{mdrOut: 1'b1, rIn: 1'b1, grb: 1'b1, default: 1'b0}, '0);
            end
            if (!isImm)
            begin
                applyStep(ctrlT'{read: 1'b1, mdrIn: 1'b1, default: 1'b0}, r.c);
                applyStep(ctrlT'{mdrOut: 1'b1, rIn: 1'b1, grc: 1'b1, default: 1'b0}, '0);
            end
            applyStep(ctrlT'{rOut: 1'b1, grb: 1'b1, yIn: 1'b1, baRead: r.base, default: 1'b0},
                      '0);
            applyStep(ctrlT'{rOut: !isImm, grc: !isImm, cOut: isImm, zIn: 1'b1, default: 1'b0},
                      '0);
            expData = want;
            expWide = (r.op == opMul);
            rowIdx  = n;
            applyStep(ctrlT'{zLowOut: 1'b1, rIn: 1'b1, gra: 1'b1, default: 1'b0}, '0);
            if (r.op == opMul)
            begin
                applyStep(ctrlT'{zHighOut: 1'b1, default: 1'b0}, '0);
            end
            prevResult = want[31:0];
        end
        applyStep('0, '0);
        @(negedge clk);
        $display("%0d of %0d rows finished, %0d check errors, %0d assertion failures",
                 rowsDone, $size(rows), errCount, i_dut.i_props.propFails);
        if ((errCount == 0) && (rowsDone == $size(rows)) && (i_dut.i_props.propFails == 0))
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Longest row is 11 steps. Four idle cycles cover start and end.
    initial
    begin
        repeat ($size(rows) * 12 + 10 + 4) @(posedge clk);
        $display("Timeout: the instruction rows did not finish in the expected number of cycles.");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- tb.f
rtl/isaPkg.sv
rtl/datapathPkg.sv
rtl/registerFile.sv
rtl/specialRegisters.sv
rtl/busMux.sv
rtl/alu.sv
rtl/datapath.sv
sim/clockGen.sv
sim/datapathProperties.sv
sim/datapathChecker.sv
sim/datapathTb.sv

//--- Bender.yml
package:
  name: datapath

sources:
  - rtl/isaPkg.sv
  - rtl/datapathPkg.sv
  - rtl/registerFile.sv
  - rtl/specialRegisters.sv
  - rtl/busMux.sv
  - rtl/alu.sv
  - rtl/datapath.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/datapathProperties.sv
      - sim/datapathChecker.sv
      - sim/datapathTb.sv
